// File: src/cce_pkg.sv
/*
 * CCE shared definitions
 * Widths, microcode opcodes, LCE message formats and the decoded instruction
 */
`default_nettype none

package cce_pkg;

  // Address and block geometry
  localparam int addr_width_lp         = 16;
  localparam int lg_block_bytes_lp     = 6;
  localparam int pending_entries_lp    = 16;
  localparam int lg_pending_entries_lp = $clog2(pending_entries_lp);

  localparam int num_lce_lp      = 4;
  localparam int lce_id_width_lp = $clog2(num_lce_lp);

  // Register file
  localparam int gpr_width_lp     = 16;
  localparam int num_gpr_lp       = 4;
  localparam int gpr_sel_width_lp = $clog2(num_gpr_lp);

  // Microcode store
  localparam int ucode_depth_lp = 64;
  localparam int pc_width_lp    = $clog2(ucode_depth_lp);
  localparam int inst_width_lp  = 32;

  typedef enum logic [3:0] {
    e_op_nop   = 4'd0,
    e_op_add   = 4'd1,
    e_op_sub   = 4'd2,
    e_op_and   = 4'd3,
    e_op_ldi   = 4'd4,
    e_op_beq   = 4'd5,
    e_op_bne   = 4'd6,
    e_op_bi    = 4'd7,
    e_op_popq  = 4'd8,
    e_op_wpnd  = 4'd9,
    e_op_rpnd  = 4'd10,
    e_op_pushc = 4'd11
  } cce_opcode_e;

  typedef enum logic [1:0] {
    e_cmd_set_s = 2'd0,
    e_cmd_set_e = 2'd1,
    e_cmd_inv   = 2'd2,
    e_cmd_wb    = 2'd3
  } lce_cmd_type_e;

  typedef struct packed {
    logic [lce_id_width_lp-1:0] lce_id;
    logic [addr_width_lp-1:0]   addr;
    logic                       write;
  } lce_req_s;

  typedef struct packed {
    lce_cmd_type_e              cmd_type;
    logic [lce_id_width_lp-1:0] lce_id;
    logic [addr_width_lp-1:0]   addr;
  } lce_cmd_s;

  typedef struct packed {
    cce_opcode_e                 opcode;
    logic [gpr_sel_width_lp-1:0] rd;
    logic [gpr_sel_width_lp-1:0] rs_a;
    logic [gpr_sel_width_lp-1:0] rs_b;
    logic [gpr_width_lp-1:0]     imm;
    logic                        addr_from_gpr;
    lce_cmd_type_e               cmd_type;
    logic                        pnd_val;
    logic                        valid;
  } decoded_inst_s;

endpackage

`default_nettype wire

// File: src/cce_msg_queue.sv
/*
 * CCE message buffer
 * Two-slot FIFO, valid/ready on the input side and valid/yumi on the output
 */
`timescale 1ns/1ps
`default_nettype none

module cce_msg_queue
  #(parameter type payload_t = logic [7:0])
  (input  wire            clk_i
   , input wire           rst_i
   , input wire payload_t data_i
   , input wire           v_i
   , output logic         ready_o
   , output payload_t     data_o
   , output logic         v_o
   , input wire           yumi_i
   );

  payload_t head_r;
  payload_t tail_r;
  logic     head_v_r;
  logic     tail_v_r;
  logic     enq;

  assign ready_o = ~tail_v_r;
  assign enq     = v_i & ready_o;

  // Head slot is always the oldest entry
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_v_r <= 1'b0;
      tail_v_r <= 1'b0;
    end else if (yumi_i) begin
      head_v_r <= tail_v_r | enq;
      tail_v_r <= 1'b0;
    end else if (enq) begin
      if (head_v_r) tail_v_r <= 1'b1;
      else          head_v_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi_i) begin
      if (tail_v_r) head_r <= tail_r;
      else if (enq) head_r <= data_i;
    end else if (enq) begin
      if (head_v_r) tail_r <= data_i;
      else          head_r <= data_i;
    end
  end

  assign data_o = head_r;
  assign v_o    = head_v_r;

endmodule

`default_nettype wire

// File: src/cce_pending.sv
/*
 * CCE pending bits
 * One bit per block address hash, combinational read
 */
`timescale 1ns/1ps
`default_nettype none

module cce_pending
  (input  wire                                clk_i
   , input wire                               rst_i
   , input wire                               w_v_i
   , input wire [cce_pkg::addr_width_lp-1:0]  addr_i
   , input wire                               val_i
   , output logic                             pending_o
   );

  import cce_pkg::*;

  logic [pending_entries_lp-1:0]    pending_r;
  logic [lg_pending_entries_lp-1:0] idx;

  // Index is the low block-number bits, so aliased blocks share a bit
  assign idx = addr_i[lg_block_bytes_lp +: lg_pending_entries_lp];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_r <= '0;
    end else if (w_v_i) begin
      pending_r[idx] <= val_i;
    end
  end

  assign pending_o = pending_r[idx];

endmodule

`default_nettype wire

// File: src/cce_msg.sv
/*
 * CCE message unit
 * Pops LCE requests, pushes LCE commands and stalls the pipeline when blocked
 */
`timescale 1ns/1ps
`default_nettype none

module cce_msg
  (input  wire cce_pkg::decoded_inst_s decoded_i
   // Request buffer head
   , input wire                        req_v_i
   , output logic                      req_yumi_o
   // Command buffer tail
   , input wire                        cmd_ready_i
   , output logic                      cmd_v_o
   , output logic                      stall_o
   );

  import cce_pkg::*;

  logic pop_op;
  logic push_op;
  logic pop_blocked;
  logic push_blocked;

  assign pop_op  = decoded_i.valid & (decoded_i.opcode == e_op_popq);
  assign push_op = decoded_i.valid & (decoded_i.opcode == e_op_pushc);

  // Nothing to pop, or nowhere to push
  assign pop_blocked  = pop_op & ~req_v_i;
  assign push_blocked = push_op & ~cmd_ready_i;

  assign req_yumi_o = pop_op & req_v_i;
  assign cmd_v_o    = push_op & cmd_ready_i;

  // Freezes fetch and decode, and holds back execute writes
  assign stall_o = pop_blocked | push_blocked;

endmodule

`default_nettype wire

// File: src/cce_ucode_fetch.sv
/*
 * CCE microcode fetch
 * Microcode RAM with its config write port and the fetch PC
 */
`timescale 1ns/1ps
`default_nettype none

module cce_ucode_fetch
  (input  wire                                 clk_i
   , input wire                                rst_i
   , input wire                                run_i
   // Microcode load port
   , input wire                                ucode_w_v_i
   , input wire [cce_pkg::pc_width_lp-1:0]     ucode_addr_i
   , input wire [cce_pkg::inst_width_lp-1:0]   ucode_data_i
   // Pipeline control
   , input wire                                stall_i
   , input wire                                redirect_i
   , input wire [cce_pkg::pc_width_lp-1:0]     redirect_pc_i
   , output logic [cce_pkg::inst_width_lp-1:0] inst_o
   , output logic                              inst_v_o
   );

  import cce_pkg::*;

  logic [inst_width_lp-1:0] ucode_mem [ucode_depth_lp];
  logic [pc_width_lp-1:0]   pc_r;

  always_ff @(posedge clk_i) begin
    if (ucode_w_v_i) begin
      ucode_mem[ucode_addr_i] <= ucode_data_i;
    end
  end

  // PC sits at 0 until the engine runs
  // A redirect kills the word being fetched this cycle
  always_ff @(posedge clk_i) begin
    if (rst_i || !run_i) begin
      pc_r     <= '0;
      inst_v_o <= 1'b0;
    end else if (redirect_i) begin
      pc_r     <= redirect_pc_i;
      inst_v_o <= 1'b0;
    end else if (!stall_i) begin
      pc_r     <= pc_r + 1'b1;
      inst_v_o <= 1'b1;
    end
  end

  // Synchronous RAM read, word lands one cycle after its PC
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_o <= ucode_mem[pc_r];
    end
  end

endmodule

`default_nettype wire

// File: src/cce_decode.sv
/*
 * CCE instruction decode
 * Registers the fetched word and splits it into control fields
 */
`timescale 1ns/1ps
`default_nettype none

module cce_decode
  (input  wire                               clk_i
   , input wire                              rst_i
   , input wire [cce_pkg::inst_width_lp-1:0] inst_i
   , input wire                              inst_v_i
   , input wire                              stall_i
   , input wire                              flush_i
   , output cce_pkg::decoded_inst_s          decoded_o
   );

  import cce_pkg::*;

  decoded_inst_s decoded_n;
  decoded_inst_s decoded_r;
  logic [3:0]    opcode_raw;

  assign opcode_raw = inst_i[31:28];

  always_comb begin
    // Opcodes past pushc are not defined and execute as nop
    if (opcode_raw > e_op_pushc) begin
      decoded_n.opcode = e_op_nop;
    end else begin
      decoded_n.opcode = cce_opcode_e'(opcode_raw);
    end
    decoded_n.rd            = inst_i[27:26];
    decoded_n.rs_a          = inst_i[25:24];
    decoded_n.rs_b          = inst_i[23:22];
    decoded_n.addr_from_gpr = inst_i[21];
    decoded_n.pnd_val       = inst_i[20];
    decoded_n.cmd_type      = lce_cmd_type_e'(inst_i[17:16]);
    decoded_n.imm           = inst_i[15:0];
    decoded_n.valid         = inst_v_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      decoded_r <= '0;
    end else if (flush_i) begin
      // Taken branch in execute, drop the wrong-path word
      decoded_r.valid <= 1'b0;
    end else if (!stall_i) begin
      decoded_r <= decoded_n;
    end
  end

  assign decoded_o = decoded_r;

endmodule

`default_nettype wire

// File: src/cce_exec.sv
/*
 * CCE execute stage
 * ALU, branch resolution, GPR file, MSHR and the outbound command fields
 */
`timescale 1ns/1ps
`default_nettype none

module cce_exec
  (input  wire                                 clk_i
   , input wire                                rst_i
   , input wire cce_pkg::decoded_inst_s        decoded_i
   , input wire                                stall_i
   , input wire cce_pkg::lce_req_s             req_i
   , input wire                                pending_i
   // Branch redirect to fetch and decode
   , output logic                              redirect_o
   , output logic [cce_pkg::pc_width_lp-1:0]   redirect_pc_o
   , output cce_pkg::lce_cmd_s                 cmd_o
   // Pending bit access
   , output logic                              pending_w_v_o
   , output logic [cce_pkg::addr_width_lp-1:0] pending_addr_o
   , output logic                              pending_val_o
   );

  import cce_pkg::*;

  logic [gpr_width_lp-1:0]    gpr_r [num_gpr_lp];
  logic [lce_id_width_lp-1:0] mshr_lce_r;
  logic [addr_width_lp-1:0]   mshr_addr_r;

  logic [gpr_width_lp-1:0] src_a;
  logic [gpr_width_lp-1:0] src_b;
  logic [gpr_width_lp-1:0] rd_data;
  logic                    rd_w_v;
  logic                    taken;
  logic                    exec_v;

  // Side effects only for a live, unstalled instruction
  assign exec_v = decoded_i.valid & ~stall_i;

  assign src_a = gpr_r[decoded_i.rs_a];
  assign src_b = gpr_r[decoded_i.rs_b];

  always_comb begin
    rd_w_v  = 1'b0;
    rd_data = '0;
    taken   = 1'b0;
    case (decoded_i.opcode)
      e_op_add:  begin rd_w_v = 1'b1; rd_data = src_a + src_b; end
      e_op_sub:  begin rd_w_v = 1'b1; rd_data = src_a - src_b; end
      e_op_and:  begin rd_w_v = 1'b1; rd_data = src_a & src_b; end
      e_op_ldi:  begin rd_w_v = 1'b1; rd_data = decoded_i.imm; end
      e_op_rpnd: begin rd_w_v = 1'b1; rd_data = gpr_width_lp'(pending_i); end
      e_op_beq:  taken = (src_a == src_b);
      e_op_bne:  taken = (src_a != src_b);
      e_op_bi:   taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < num_gpr_lp; i++) begin
        gpr_r[i] <= '0;
      end
    end else if (exec_v && rd_w_v) begin
      gpr_r[decoded_i.rd] <= rd_data;
    end
  end

  // popq only proceeds once the message unit has a request ready
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mshr_lce_r  <= '0;
      mshr_addr_r <= '0;
    end else if (exec_v && decoded_i.opcode == e_op_popq) begin
      mshr_lce_r  <= req_i.lce_id;
      mshr_addr_r <= req_i.addr;
    end
  end

  assign redirect_o    = exec_v & taken;
  assign redirect_pc_o = decoded_i.imm[pc_width_lp-1:0];

  assign pending_w_v_o  = exec_v & (decoded_i.opcode == e_op_wpnd);
  assign pending_addr_o = mshr_addr_r;
  assign pending_val_o  = decoded_i.pnd_val;

  always_comb begin
    cmd_o.cmd_type = decoded_i.cmd_type;
    cmd_o.lce_id   = mshr_lce_r;
    cmd_o.addr     = decoded_i.addr_from_gpr ? src_a : mshr_addr_r;
  end

endmodule

`default_nettype wire

// File: src/cce_top.sv
/*
 * CCE top level
 * Microcoded coherence engine, fetch/decode/execute with LCE message buffers
 */
`timescale 1ns/1ps
`default_nettype none

module cce_top
  (input  wire                                clk_i
   , input wire                               rst_i
   , input wire                               run_i
   // Microcode load
   , input wire                               ucode_w_v_i
   , input wire [cce_pkg::pc_width_lp-1:0]    ucode_addr_i
   , input wire [cce_pkg::inst_width_lp-1:0]  ucode_data_i
   // LCE requests in
   , input wire cce_pkg::lce_req_s            lce_req_i
   , input wire                               lce_req_v_i
   , output logic                             lce_req_yumi_o
   // LCE commands out
   , output cce_pkg::lce_cmd_s                lce_cmd_o
   , output logic                             lce_cmd_v_o
   , input wire                               lce_cmd_ready_i
   );

  import cce_pkg::*;

  logic [inst_width_lp-1:0] fetch_inst_lo;
  logic                     fetch_inst_v_lo;
  decoded_inst_s            decoded_inst_lo;
  logic                     redirect_lo;
  logic [pc_width_lp-1:0]   redirect_pc_lo;
  logic                     stall_lo;

  logic                     pending_lo;
  logic                     pending_w_v_lo;
  logic [addr_width_lp-1:0] pending_addr_lo;
  logic                     pending_val_lo;

  lce_req_s req_lo;
  logic     req_v_lo;
  logic     req_ready_lo;
  logic     req_yumi_lo;
  lce_cmd_s cmd_lo;
  logic     cmd_v_lo;
  logic     cmd_ready_lo;
  logic     cmd_yumi_li;

  assign lce_req_yumi_o = lce_req_v_i & req_ready_lo;
  assign cmd_yumi_li    = lce_cmd_v_o & lce_cmd_ready_i;

  cce_ucode_fetch ucode_fetch
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.run_i(run_i)
     ,.ucode_w_v_i(ucode_w_v_i)
     ,.ucode_addr_i(ucode_addr_i)
     ,.ucode_data_i(ucode_data_i)
     ,.stall_i(stall_lo)
     ,.redirect_i(redirect_lo)
     ,.redirect_pc_i(redirect_pc_lo)
     ,.inst_o(fetch_inst_lo)
     ,.inst_v_o(fetch_inst_v_lo)
     );

  cce_decode inst_decode
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.inst_i(fetch_inst_lo)
     ,.inst_v_i(fetch_inst_v_lo)
     ,.stall_i(stall_lo)
     ,.flush_i(redirect_lo)
     ,.decoded_o(decoded_inst_lo)
     );

  cce_exec exec
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.decoded_i(decoded_inst_lo)
     ,.stall_i(stall_lo)
     ,.req_i(req_lo)
     ,.pending_i(pending_lo)
     ,.redirect_o(redirect_lo)
     ,.redirect_pc_o(redirect_pc_lo)
     ,.cmd_o(cmd_lo)
     ,.pending_w_v_o(pending_w_v_lo)
     ,.pending_addr_o(pending_addr_lo)
     ,.pending_val_o(pending_val_lo)
     );

  cce_pending pending_bits
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.w_v_i(pending_w_v_lo)
     ,.addr_i(pending_addr_lo)
     ,.val_i(pending_val_lo)
     ,.pending_o(pending_lo)
     );

  cce_msg msg_unit
    (.decoded_i(decoded_inst_lo)
     ,.req_v_i(req_v_lo)
     ,.req_yumi_o(req_yumi_lo)
     ,.cmd_ready_i(cmd_ready_lo)
     ,.cmd_v_o(cmd_v_lo)
     ,.stall_o(stall_lo)
     );

  cce_msg_queue #(.payload_t(lce_req_s)) req_queue
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.data_i(lce_req_i)
     ,.v_i(lce_req_v_i)
     ,.ready_o(req_ready_lo)
     ,.data_o(req_lo)
     ,.v_o(req_v_lo)
     ,.yumi_i(req_yumi_lo)
     );

  cce_msg_queue #(.payload_t(lce_cmd_s)) cmd_queue
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.data_i(cmd_lo)
     ,.v_i(cmd_v_lo)
     ,.ready_o(cmd_ready_lo)
     ,.data_o(lce_cmd_o)
     ,.v_o(lce_cmd_v_o)
     ,.yumi_i(cmd_yumi_li)
     );

endmodule

`default_nettype wire

// File: testbench/tb_cce.sv
/*
 * CCE testbench
 * Loads microcode, drives LCE requests and checks the LCE commands that come out
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cce;

  import cce_pkg::*;

  localparam int num_tests_lp   = 6;
  localparam int test_cycles_lp = 300;
  // Two budgets per test, plus reset and slack
  localparam int max_cycles_lp  = 2 * num_tests_lp * test_cycles_lp + 400;
  localparam int wait_limit_lp  = 200;

  logic                     clk_i;
  logic                     rst_i;
  logic                     run_i;
  logic                     ucode_w_v_i;
  logic [pc_width_lp-1:0]   ucode_addr_i;
  logic [inst_width_lp-1:0] ucode_data_i;
  lce_req_s                 lce_req_i;
  logic                     lce_req_v_i;
  logic                     lce_req_yumi_o;
  lce_cmd_s                 lce_cmd_o;
  logic                     lce_cmd_v_o;
  logic                     lce_cmd_ready_i;

  logic [31:0] lcg_state;
  int          cycle_count;
  int          error_count;
  int          pass_count;
  int          fail_count;
  int          yumi_count;
  int          yumi_base;
  int          cmd_base;
  logic [1:0]  mshr_lce_model;
  logic [31:0] prog_q[$];
  lce_cmd_s    exp_q[$];
  lce_cmd_s    cmd_q[$];

  cce_top i_dut
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.run_i(run_i)
     ,.ucode_w_v_i(ucode_w_v_i)
     ,.ucode_addr_i(ucode_addr_i)
     ,.ucode_data_i(ucode_data_i)
     ,.lce_req_i(lce_req_i)
     ,.lce_req_v_i(lce_req_v_i)
     ,.lce_req_yumi_o(lce_req_yumi_o)
     ,.lce_cmd_o(lce_cmd_o)
     ,.lce_cmd_v_o(lce_cmd_v_o)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Records every command transfer and request handshake
  always @(posedge clk_i) begin
    if (lce_cmd_v_o && lce_cmd_ready_i) begin
      cmd_q.push_back(lce_cmd_o);
    end
    if (lce_req_yumi_o) begin
      yumi_count++;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles_lp) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("ERROR: run did not finish within %0d cycles", cycle_count);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [31:0] encode(input cce_opcode_e op, input int rd, input int rs_a,
                                         input int rs_b, input logic from_gpr, input logic pnd,
                                         input lce_cmd_type_e cmd, input int imm);
    logic [31:0] w;
    w = '0;
    w[31:28] = op;
    w[27:26] = rd[1:0];
    w[25:24] = rs_a[1:0];
    w[23:22] = rs_b[1:0];
    w[21]    = from_gpr;
    w[20]    = pnd;
    w[17:16] = cmd;
    w[15:0]  = imm[15:0];
    return w;
  endfunction

  function automatic logic [31:0] ldi_inst(input int rd, input logic [15:0] imm);
    return encode(e_op_ldi, rd, 0, 0, 1'b0, 1'b0, e_cmd_set_s, int'(imm));
  endfunction

  function automatic logic [31:0] alu_inst(input cce_opcode_e op, input int rd, input int rs_a,
                                           input int rs_b);
    return encode(op, rd, rs_a, rs_b, 1'b0, 1'b0, e_cmd_set_s, 0);
  endfunction

  function automatic logic [31:0] br_inst(input cce_opcode_e op, input int rs_a, input int rs_b,
                                          input int target);
    return encode(op, 0, rs_a, rs_b, 1'b0, 1'b0, e_cmd_set_s, target);
  endfunction

  function automatic logic [31:0] push_inst(input lce_cmd_type_e cmd, input logic from_gpr,
                                            input int rs_a);
    return encode(e_op_pushc, 0, rs_a, 0, from_gpr, 1'b0, cmd, 0);
  endfunction

  function automatic logic [31:0] op_inst(input cce_opcode_e op, input logic pnd);
    return encode(op, 0, 0, 0, 1'b0, pnd, e_cmd_set_s, 0);
  endfunction

  function automatic lce_cmd_s make_cmd(input lce_cmd_type_e t, input logic [1:0] lce,
                                        input logic [15:0] addr);
    lce_cmd_s c;
    c.cmd_type = t;
    c.lce_id   = lce;
    c.addr     = addr;
    return c;
  endfunction

  task automatic check_cmd(input string name, input lce_cmd_s exp, input lce_cmd_s act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected type %0d lce %0d addr %h, actual type %0d lce %0d addr %h",
               name, exp.cmd_type, exp.lce_id, exp.addr, act.cmd_type, act.lce_id, act.addr);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s %s: expected %0d actual %0d", name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // Engine stopped, whole RAM written, engine started again
  task automatic load_program();
    int i;
    @(negedge clk_i);
    run_i = 1'b0;
    repeat (3) @(negedge clk_i);
    for (i = 0; i < ucode_depth_lp; i++) begin
      ucode_w_v_i  = 1'b1;
      ucode_addr_i = i[pc_width_lp-1:0];
      // Unused words branch to themselves, so the engine parks there
      ucode_data_i = (i < prog_q.size()) ? prog_q[i] : br_inst(e_op_bi, 0, 0, i);
      @(negedge clk_i);
    end
    ucode_w_v_i = 1'b0;
    prog_q.delete();
    cmd_base  = cmd_q.size();
    yumi_base = yumi_count;
    run_i     = 1'b1;
  endtask

  task automatic send_req(input string name, input logic [1:0] lce, input logic [15:0] addr);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    lce_req_i.lce_id = lce;
    lce_req_i.addr   = addr;
    lce_req_i.write  = 1'b0;
    lce_req_v_i      = 1'b1;
    while (!accepted && waited < wait_limit_lp) begin
      @(posedge clk_i);
      accepted = lce_req_yumi_o;
      waited++;
    end
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
    if (!accepted) begin
      $display("ERROR: %s: request was never accepted", name);
      error_count++;
    end else begin
      mshr_lce_model = lce;
    end
  endtask

  // Waits for the expected commands, lets extra ones show up, then compares
  task automatic collect_cmds(input string name, input int settle);
    int waited;
    int got;
    int i;
    waited = 0;
    while (cmd_q.size() - cmd_base < exp_q.size() && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (waited >= wait_limit_lp) begin
      $display("ERROR: %s: gave up waiting for commands", name);
      error_count++;
    end
    repeat (settle) @(negedge clk_i);
    got = cmd_q.size() - cmd_base;
    check_count(name, "commands", exp_q.size(), got);
    for (i = 0; i < exp_q.size() && i < got; i++) begin
      check_cmd(name, exp_q[i], cmd_q[cmd_base + i]);
    end
    exp_q.delete();
  endtask

  task automatic test_alu();
    int          errors_before;
    logic [15:0] a;
    logic [15:0] b;
    errors_before = error_count;
    a = 16'h1234;
    b = 16'h0100;
    prog_q.push_back(ldi_inst(0, a));
    prog_q.push_back(ldi_inst(1, b));
    prog_q.push_back(alu_inst(e_op_add, 2, 0, 1));
    prog_q.push_back(alu_inst(e_op_sub, 3, 0, 1));
    prog_q.push_back(alu_inst(e_op_and, 1, 0, 3));
    prog_q.push_back(push_inst(e_cmd_set_s, 1'b1, 2));
    prog_q.push_back(push_inst(e_cmd_set_e, 1'b1, 3));
    prog_q.push_back(push_inst(e_cmd_wb, 1'b1, 1));
    load_program();
    exp_q.push_back(make_cmd(e_cmd_set_s, mshr_lce_model, a + b));
    exp_q.push_back(make_cmd(e_cmd_set_e, mshr_lce_model, a - b));
    exp_q.push_back(make_cmd(e_cmd_wb, mshr_lce_model, a & (a - b)));
    collect_cmds("alu", 10);
    finish_test("alu", errors_before);
  endtask

  task automatic test_req_to_cmd();
    int          errors_before;
    logic [15:0] addr;
    errors_before = error_count;
    addr = lcg_next() & 16'hffc0;
    prog_q.push_back(op_inst(e_op_popq, 1'b0));
    prog_q.push_back(push_inst(e_cmd_set_e, 1'b0, 0));
    load_program();
    send_req("req_to_cmd", 2'd2, addr);
    exp_q.push_back(make_cmd(e_cmd_set_e, 2'd2, addr));
    collect_cmds("req_to_cmd", 10);
    check_count("req_to_cmd", "request handshakes", 1, yumi_count - yumi_base);
    finish_test("req_to_cmd", errors_before);
  endtask

  task automatic test_branch();
    int          errors_before;
    logic [15:0] cnt;
    logic [15:0] limit;
    errors_before = error_count;
    limit = 16'd2;
    prog_q.push_back(ldi_inst(0, 16'd5));
    prog_q.push_back(ldi_inst(1, 16'd5));
    prog_q.push_back(ldi_inst(2, 16'd0));
    prog_q.push_back(ldi_inst(3, 16'd1));
    prog_q.push_back(br_inst(e_op_beq, 0, 1, 6));
    prog_q.push_back(push_inst(e_cmd_inv, 1'b1, 0));
    prog_q.push_back(push_inst(e_cmd_set_s, 1'b1, 0));
    prog_q.push_back(br_inst(e_op_bne, 0, 1, 5));
    prog_q.push_back(ldi_inst(0, limit));
    // Loop body at 9, counter in r2
    prog_q.push_back(push_inst(e_cmd_set_e, 1'b1, 2));
    prog_q.push_back(alu_inst(e_op_add, 2, 2, 3));
    prog_q.push_back(br_inst(e_op_beq, 2, 0, 13));
    prog_q.push_back(br_inst(e_op_bi, 0, 0, 9));
    prog_q.push_back(push_inst(e_cmd_wb, 1'b1, 2));
    load_program();
    exp_q.push_back(make_cmd(e_cmd_set_s, mshr_lce_model, 16'd5));
    for (cnt = 16'd0; cnt < limit; cnt++) begin
      exp_q.push_back(make_cmd(e_cmd_set_e, mshr_lce_model, cnt));
    end
    exp_q.push_back(make_cmd(e_cmd_wb, mshr_lce_model, limit));
    collect_cmds("branch", 10);
    finish_test("branch", errors_before);
  endtask

  task automatic test_pending();
    int          errors_before;
    logic [15:0] addr_a;
    logic [15:0] addr_b;
    errors_before = error_count;
    addr_a = lcg_next() & 16'hffc0;
    // Differs above the index bits, so both share one pending bit
    addr_b = addr_a ^ 16'h0400;
    prog_q.push_back(ldi_inst(0, 16'd0));
    prog_q.push_back(op_inst(e_op_popq, 1'b0));
    prog_q.push_back(op_inst(e_op_wpnd, 1'b1));
    prog_q.push_back(op_inst(e_op_popq, 1'b0));
    prog_q.push_back(alu_inst(e_op_rpnd, 3, 0, 0));
    prog_q.push_back(br_inst(e_op_bne, 3, 0, 7));
    prog_q.push_back(br_inst(e_op_bi, 0, 0, 6));
    prog_q.push_back(push_inst(e_cmd_set_s, 1'b0, 0));
    load_program();
    send_req("pending", 2'd1, addr_a);
    send_req("pending", 2'd3, addr_b);
    exp_q.push_back(make_cmd(e_cmd_set_s, 2'd3, addr_b));
    collect_cmds("pending", 10);
    check_count("pending", "request handshakes", 2, yumi_count - yumi_base);
    // Second pass clears the bit, so the branch falls into the parking loop
    prog_q.push_back(ldi_inst(0, 16'd0));
    prog_q.push_back(op_inst(e_op_popq, 1'b0));
    prog_q.push_back(op_inst(e_op_wpnd, 1'b0));
    prog_q.push_back(alu_inst(e_op_rpnd, 3, 0, 0));
    prog_q.push_back(br_inst(e_op_bne, 3, 0, 6));
    prog_q.push_back(br_inst(e_op_bi, 0, 0, 5));
    prog_q.push_back(push_inst(e_cmd_set_s, 1'b0, 0));
    load_program();
    send_req("pending", 2'd1, addr_a);
    collect_cmds("pending", 40);
    finish_test("pending", errors_before);
  endtask

  task automatic test_backpressure();
    int          errors_before;
    int          k;
    logic [15:0] addrs [5];
    errors_before = error_count;
    lce_cmd_ready_i = 1'b0;
    for (k = 0; k < 5; k++) begin
      addrs[k] = lcg_next();
      prog_q.push_back(ldi_inst(k % 4, addrs[k]));
      prog_q.push_back(push_inst(lce_cmd_type_e'(k[1:0]), 1'b1, k % 4));
    end
    load_program();
    for (k = 0; k < 5; k++) begin
      exp_q.push_back(make_cmd(lce_cmd_type_e'(k[1:0]), mshr_lce_model, addrs[k]));
    end
    repeat (40) @(negedge clk_i);
    // Oldest command waits at the head until the LCE takes it
    check_count("backpressure", "valid while blocked", 1, int'(lce_cmd_v_o));
    check_cmd("backpressure", exp_q[0], lce_cmd_o);
    lce_cmd_ready_i = 1'b1;
    collect_cmds("backpressure", 10);
    finish_test("backpressure", errors_before);
  endtask

  task automatic test_req_stall();
    int          errors_before;
    logic [15:0] addr;
    errors_before = error_count;
    prog_q.push_back(op_inst(e_op_popq, 1'b0));
    prog_q.push_back(push_inst(e_cmd_inv, 1'b0, 0));
    load_program();
    repeat (50) @(negedge clk_i);
    check_count("req_stall", "commands before request", 0, cmd_q.size() - cmd_base);
    addr = lcg_next() & 16'hffc0;
    send_req("req_stall", 2'd1, addr);
    exp_q.push_back(make_cmd(e_cmd_inv, 2'd1, addr));
    collect_cmds("req_stall", 10);
    finish_test("req_stall", errors_before);
  endtask

  initial begin
    rst_i           = 1'b1;
    run_i           = 1'b0;
    ucode_w_v_i     = 1'b0;
    ucode_addr_i    = '0;
    ucode_data_i    = '0;
    lce_req_i       = '0;
    lce_req_v_i     = 1'b0;
    lce_cmd_ready_i = 1'b1;
    lcg_state       = 32'd32;
    error_count     = 0;
    pass_count      = 0;
    fail_count      = 0;
    yumi_base       = 0;
    cmd_base        = 0;
    mshr_lce_model  = '0;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    test_alu();
    test_req_to_cmd();
    test_branch();
    test_pending();
    test_backpressure();
    test_req_stall();
    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/cce_pkg.sv
src/cce_msg_queue.sv
src/cce_pending.sv
src/cce_msg.sv
src/cce_ucode_fetch.sv
src/cce_decode.sv
src/cce_exec.sv
src/cce_top.sv
testbench/tb_cce.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_cce
RTL_TOP     ?= cce_top
FILELIST    ?= list.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing -j 0
LINT_FLAGS  ?= -Wall
RTL_SRCS    ?= $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
